//--- hdl/vdiv_pkg.sv
// FP16 vector divide unit shared definitions
// FP16 and APB request/response structs, sequencer states and the
// APB register map used by the register block and the testbench
package vdiv_pkg;

    // One half-precision value
    typedef struct packed {
        logic       sign;
        logic [4:0] exp;
        logic [9:0] mant;
    } fp16_t;

    // APB requester side
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // APB completer side
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_RUN,
        SEQ_WRITEBACK
    } seq_state_t;

    // Register map, lane i sits at base + 4*i
    localparam logic [7:0] REG_CTRL   = 8'h00;
    localparam logic [7:0] REG_STATUS = 8'h04;
    localparam logic [7:0] REG_A_BASE = 8'h10;
    localparam logic [7:0] REG_B_BASE = 8'h20;
    localparam logic [7:0] REG_R_BASE = 8'h30;

    // Quiet NaN, exponent all ones and mantissa MSB set
    localparam logic [15:0] FP16_QNAN = 16'h7e00;

endpackage

//--- hdl/int_divider.sv
// Iterative unsigned integer divider
// Restoring shift-subtract, one quotient bit per clock. The leading SKIP
// quotient bits are known to be zero, so the first step happens in the
// enable cycle at bit SIZE-SKIP-1 and done follows SIZE-SKIP cycles later
`timescale 1ns/1ps

module int_divider #(
    parameter int SIZE = 23,
    parameter int SKIP = 11
) (
    input  logic            CLK,
    input  logic            nRST,
    input  logic            en,
    input  logic [SIZE-1:0] x,
    input  logic [SIZE-1:0] y,
    output logic [SIZE-1:0] result,
    output logic            done
);

    localparam int STEPS = SIZE - SKIP;
    localparam int CW    = $clog2(SIZE);

    logic [SIZE-1:0] rem_q;
    logic [SIZE-1:0] x_q;
    logic [SIZE-1:0] y_q;
    logic [SIZE-1:0] quot_q;
    logic [CW-1:0]   cnt_q;
    logic            run_q;

    logic [SIZE-1:0] rem_cur;
    logic [SIZE-1:0] x_cur;
    logic [SIZE-1:0] y_cur;
    logic [SIZE-1:0] trial;
    logic [CW-1:0]   idx;
    logic            fit;
    logic            step;

    assign step = en | run_q;

    // Operands come straight from the ports on the first step
    always_comb begin
        if (en) begin
            rem_cur = x >> STEPS;
            x_cur   = x;
            y_cur   = y;
            idx     = CW'(STEPS - 1);
        end else begin
            rem_cur = rem_q;
            x_cur   = x_q;
            y_cur   = y_q;
            idx     = cnt_q;
        end
        trial = {rem_cur[SIZE-2:0], x_cur[idx]};
        fit   = (trial >= y_cur);
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            run_q <= 1'b0;
            cnt_q <= '0;
            done  <= 1'b0;
        end else begin
            done <= step && (idx == '0);
            if (step) begin
                run_q <= (idx != '0);
                cnt_q <= idx - 1'b1;
            end
        end
    end

    // Quotient shifts in from the bottom, one bit per step
    always_ff @(posedge CLK) begin
        if (step) begin
            rem_q  <= fit ? (trial - y_cur) : trial;
            x_q    <= x_cur;
            y_q    <= y_cur;
            quot_q <= en ? SIZE'(fit) : {quot_q[SIZE-2:0], fit};
        end
    end

    assign result = quot_q;

endmodule

//--- hdl/fp16_div.sv
// Single-lane FP16 divide functional unit
// NaN, infinity and zero results bypass the divider and finish in one
// cycle. Normal operands go through the mantissa divider, then the result
// is normalized, shifted into subnormal range if needed and rounded half-up
`timescale 1ns/1ps

module fp16_div import vdiv_pkg::*; #(
    parameter int DIV_SIZE = 23,
    parameter int DIV_SKIP = 11
) (
    input  logic  CLK,
    input  logic  nRST,
    input  logic  en,
    input  fp16_t a,
    input  fp16_t b,
    output fp16_t result,
    output logic  done
);

    localparam int QW = DIV_SIZE - DIV_SKIP;

    logic a_zero, b_zero, a_inf, b_inf, a_nan, b_nan;
    logic is_nan, is_inf, is_zero, skip;
    logic sign;
    logic [10:0] sig_a;
    logic [10:0] sig_b;
    logic lt;
    logic [DIV_SIZE-1:0] div_x;
    logic [DIV_SIZE-1:0] div_y;
    logic [DIV_SIZE-1:0] quot;
    logic div_done;
    logic armed_q;
    logic fire;
    logic [11:0] sig_q;
    logic signed [6:0] exp_raw;
    logic signed [6:0] shift_full;
    logic [4:0] sub_shift;
    logic [11:0] sig_sh;
    logic [4:0] exp_fld;
    logic [14:0] rounded;
    logic ovf;

    // Subnormal inputs are flushed to zero
    assign a_zero = (a.exp == 5'd0);
    assign b_zero = (b.exp == 5'd0);
    assign a_inf  = (&a.exp) && (a.mant == 10'd0);
    assign b_inf  = (&b.exp) && (b.mant == 10'd0);
    assign a_nan  = (&a.exp) && (a.mant != 10'd0);
    assign b_nan  = (&b.exp) && (b.mant != 10'd0);

    assign is_nan  = a_nan | b_nan | (a_zero & b_zero) | (a_inf & b_inf);
    assign is_inf  = ~is_nan & (a_inf | b_zero);
    assign is_zero = ~is_nan & ~is_inf & (a_zero | b_inf);
    assign skip    = is_nan | is_inf | is_zero;
    assign sign    = a.sign ^ b.sign;

    // Pre-scale the dividend so the quotient always has its leading one
    // at bit QW-1, whichever mantissa is larger
    assign sig_a = {1'b1, a.mant};
    assign sig_b = {1'b1, b.mant};
    assign lt    = (sig_a < sig_b);
    assign div_x = DIV_SIZE'(sig_a) << (QW - 1 + int'(lt));
    assign div_y = DIV_SIZE'(sig_b);

    int_divider #(
        .SIZE(DIV_SIZE),
        .SKIP(DIV_SKIP)
    ) divider_i (
        .CLK   (CLK),
        .nRST  (nRST),
        .en    (en & ~skip),
        .x     (div_x),
        .y     (div_y),
        .result(quot),
        .done  (div_done)
    );

    // Leading one, ten mantissa bits and the guard bit
    assign sig_q = quot[QW-1 -: 12];

    assign exp_raw = $signed({2'b00, a.exp}) - $signed({2'b00, b.exp})
                   + 7'sd15 - $signed({6'b0, lt});
    assign shift_full = 7'sd1 - exp_raw;
    assign sub_shift  = shift_full[4:0];
    assign ovf        = (exp_raw > 7'sd30);

    always_comb begin
        if (exp_raw <= 7'sd0) begin
            // Subnormal result, hidden bit moves into the fraction
            sig_sh  = sig_q >> sub_shift;
            exp_fld = 5'd0;
        end else begin
            sig_sh  = sig_q;
            exp_fld = exp_raw[4:0];
        end
    end

    // Carry out of the mantissa bumps the exponent, up to infinity
    assign rounded = {exp_fld, sig_sh[10:1]} + 15'(sig_sh[0]);

    always_comb begin
        if (is_nan)
            result = {sign, FP16_QNAN[14:0]};
        else if (is_inf || ovf)
            result = {sign, 5'h1f, 10'h000};
        else if (is_zero)
            result = {sign, 15'h0000};
        else
            result = {sign, rounded};
    end

    // One done pulse per operation
    assign fire = (en & skip) | (armed_q & div_done);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            armed_q <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= fire;
            if (en)
                armed_q <= ~skip;
            else if (div_done)
                armed_q <= 1'b0;
        end
    end

endmodule

//--- hdl/vdiv_regs.sv
// APB register block of the vector divide unit
// Control, status, per-lane operand and result registers. Operand and
// start writes are refused with pslverr while a divide is running
`timescale 1ns/1ps

module vdiv_regs import vdiv_pkg::*; #(
    parameter int LANES = 4
) (
    input  logic                 CLK,
    input  logic                 nRST,
    input  apb_req_t             apb_req,
    output apb_rsp_t             apb_rsp,
    input  logic                 busy,
    input  logic                 done_pulse,
    input  logic [LANES-1:0]     res_we,
    input  fp16_t [LANES-1:0]    res,
    output logic                 start,
    output fp16_t [LANES-1:0]    opa,
    output fp16_t [LANES-1:0]    opb
);

    logic access;
    logic wr;
    logic [1:0] lane;
    logic lane_ok;
    logic hit_ctrl, hit_status, hit_a, hit_b, hit_r;
    logic mapped;
    logic blocked;
    logic done_q;
    fp16_t [LANES-1:0] opa_q;
    fp16_t [LANES-1:0] opb_q;
    fp16_t [LANES-1:0] res_q;

    assign access = apb_req.psel & apb_req.penable;
    assign wr     = access & apb_req.pwrite;

    // Address decode
    assign lane       = apb_req.paddr[3:2];
    assign lane_ok    = (apb_req.paddr[1:0] == 2'b00) && (int'(lane) < LANES);
    assign hit_ctrl   = (apb_req.paddr == REG_CTRL);
    assign hit_status = (apb_req.paddr == REG_STATUS);
    assign hit_a      = (apb_req.paddr[7:4] == REG_A_BASE[7:4]) && lane_ok;
    assign hit_b      = (apb_req.paddr[7:4] == REG_B_BASE[7:4]) && lane_ok;
    assign hit_r      = (apb_req.paddr[7:4] == REG_R_BASE[7:4]) && lane_ok;
    assign mapped     = hit_ctrl | hit_status | hit_a | hit_b | hit_r;

    assign blocked = busy & apb_req.pwrite
                   & (hit_a | hit_b | (hit_ctrl & apb_req.pwdata[0]));

    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access & (~mapped | blocked);

    assign start = wr & hit_ctrl & apb_req.pwdata[0] & ~busy;

    // Sticky done, cleared by the next start
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST)
            done_q <= 1'b0;
        else if (start)
            done_q <= 1'b0;
        else if (done_pulse)
            done_q <= 1'b1;
    end

    always_ff @(posedge CLK) begin
        for (int i = 0; i < LANES; i++) begin
            if (wr && !busy && hit_a && lane == 2'(i))
                opa_q[i] <= apb_req.pwdata[15:0];
            if (wr && !busy && hit_b && lane == 2'(i))
                opb_q[i] <= apb_req.pwdata[15:0];
            if (res_we[i])
                res_q[i] <= res[i];
        end
    end

    // Read data, zero-extended
    always_comb begin
        apb_rsp.prdata = 32'h0;
        if (hit_status)
            apb_rsp.prdata = {30'h0, done_q, busy};
        for (int i = 0; i < LANES; i++) begin
            if (lane == 2'(i)) begin
                if (hit_a)
                    apb_rsp.prdata = {16'h0, opa_q[i]};
                if (hit_b)
                    apb_rsp.prdata = {16'h0, opb_q[i]};
                if (hit_r)
                    apb_rsp.prdata = {16'h0, res_q[i]};
            end
        end
    end

    assign opa = opa_q;
    assign opb = opb_q;

endmodule

//--- hdl/vdiv_seq.sv
// Vector divide sequencer
// Issues one enable to every lane, then collects each lane's result on
// its done pulse. When no lane is pending it spends one cycle in
// writeback, pulses done and drops busy
`timescale 1ns/1ps

module vdiv_seq import vdiv_pkg::*; #(
    parameter int LANES = 4
) (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               start,
    input  logic [LANES-1:0]   lane_done,
    input  fp16_t [LANES-1:0]  lane_res,
    output logic               en,
    output logic               busy,
    output logic               done_pulse,
    output logic [LANES-1:0]   res_we,
    output fp16_t [LANES-1:0]  res
);

    seq_state_t state_q;
    logic [LANES-1:0] pending_q;
    logic [LANES-1:0] pending_left;

    assign pending_left = pending_q & ~lane_done;

    // Result registers load in the cycle the lane reports done
    assign res_we     = (state_q == SEQ_RUN) ? (pending_q & lane_done) : '0;
    assign res        = lane_res;
    assign busy       = (state_q != SEQ_IDLE);
    assign done_pulse = (state_q == SEQ_WRITEBACK);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state_q   <= SEQ_IDLE;
            pending_q <= '0;
            en        <= 1'b0;
        end else begin
            en <= 1'b0;
            case (state_q)
                SEQ_IDLE: begin
                    if (start) begin
                        state_q   <= SEQ_RUN;
                        pending_q <= '1;
                        en        <= 1'b1;
                    end
                end
                SEQ_RUN: begin
                    pending_q <= pending_left;
                    if (pending_left == '0)
                        state_q <= SEQ_WRITEBACK;
                end
                SEQ_WRITEBACK: state_q <= SEQ_IDLE;
                default:       state_q <= SEQ_IDLE;
            endcase
        end
    end

endmodule

//--- hdl/vdiv_top.sv
// Vector FP16 divide unit top level
// APB register block, sequencer and LANES divide lanes
`timescale 1ns/1ps

module vdiv_top import vdiv_pkg::*; #(
    parameter int LANES    = 4,
    parameter int DIV_SIZE = 23,
    parameter int DIV_SKIP = 11
) (
    input  logic     CLK,
    input  logic     nRST,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);

    logic start;
    logic busy;
    logic done_pulse;
    logic en;
    logic [LANES-1:0] res_we;
    logic [LANES-1:0] lane_done;
    fp16_t [LANES-1:0] opa;
    fp16_t [LANES-1:0] opb;
    fp16_t [LANES-1:0] res;
    fp16_t [LANES-1:0] lane_res;

    vdiv_regs #(
        .LANES(LANES)
    ) regs_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .busy      (busy),
        .done_pulse(done_pulse),
        .res_we    (res_we),
        .res       (res),
        .start     (start),
        .opa       (opa),
        .opb       (opb)
    );

    vdiv_seq #(
        .LANES(LANES)
    ) seq_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .start     (start),
        .lane_done (lane_done),
        .lane_res  (lane_res),
        .en        (en),
        .busy      (busy),
        .done_pulse(done_pulse),
        .res_we    (res_we),
        .res       (res)
    );

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        fp16_div #(
            .DIV_SIZE(DIV_SIZE),
            .DIV_SKIP(DIV_SKIP)
        ) lane_i (
            .CLK   (CLK),
            .nRST  (nRST),
            .en    (en),
            .a     (opa[i]),
            .b     (opb[i]),
            .result(lane_res[i]),
            .done  (lane_done[i])
        );
    end

endmodule

//--- testbench/vdiv_clk_gen.sv
// Testbench clock and reset generator
// Free-running clock, reset held low for RESET_CYCLES rising edges
`timescale 1ns/1ps

module vdiv_clk_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    // Release on a falling edge, away from the active clock edge
    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
    end

endmodule

//--- testbench/vdiv_asserts.sv
// Protocol and timing checks for the vector divide unit
// Bound into the sequencer and the register block. Inputs that do not
// exist in a bound module are tied low at the bind
`timescale 1ns/1ps

module vdiv_asserts (
    input logic CLK,
    input logic nRST,
    input logic done_pulse,
    input logic en,
    input logic busy,
    input logic psel,
    input logic penable,
    input logic pslverr
);

    int fail_count = 0;

    // Writeback lasts exactly one cycle
    a_done_one_cycle: assert property (
        @(posedge CLK) disable iff (!nRST) done_pulse |=> !done_pulse
    ) else begin
        $error("done_pulse stayed high for more than one cycle");
        fail_count++;
    end

    // Lanes are only started from idle
    a_en_from_idle: assert property (
        @(posedge CLK) disable iff (!nRST) en |-> !$past(busy)
    ) else begin
        $error("en pulsed while the sequencer was already busy");
        fail_count++;
    end

    a_slverr_access: assert property (
        @(posedge CLK) disable iff (!nRST) pslverr |-> (psel && penable)
    ) else begin
        $error("pslverr raised outside an APB access phase");
        fail_count++;
    end

endmodule

bind vdiv_seq vdiv_asserts seq_chk_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .done_pulse(done_pulse),
    .en        (en),
    .busy      (busy),
    .psel      (1'b0),
    .penable   (1'b0),
    .pslverr   (1'b0)
);

bind vdiv_regs vdiv_asserts regs_chk_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .done_pulse(done_pulse),
    .en        (1'b0),
    .busy      (busy),
    .psel      (apb_req.psel),
    .penable   (apb_req.penable),
    .pslverr   (apb_rsp.pslverr)
);

//--- testbench/vdiv_tb.sv
// Testbench for the vector FP16 divide unit
// Table-driven APB stimulus with per-lane result checks, status and
// error response checks, random special-value vectors and a watchdog
`timescale 1ns/1ps

module vdiv_tb import vdiv_pkg::*; ();

    localparam int LANES         = 4;
    localparam int CLK_PERIOD    = 20;
    localparam int NUM_ROWS      = 8;
    localparam int NUM_RAND      = 6;
    localparam int ROW_CYCLES    = 40;
    localparam int MARGIN_CYCLES = 1000;
    localparam int POLL_LIMIT    = 50;

    // Each entry is {a, b, expected a/b}, lanes 0 to 3 left to right
    localparam logic [47:0] VECS [NUM_ROWS][LANES] = '{
        // Normal quotients where 5/3 and -7/3 round up on the guard bit
        '{48'h4600_4000_4200, 48'h3c00_4200_3555, 48'h4500_4200_3eab, 48'hc700_4200_c0ab},
        '{48'hc600_4000_c200, 48'h4600_c000_c200, 48'hc600_c000_4200, 48'h3c00_3c00_3c00},
        // NaN operand, 0/0, inf/inf
        '{48'h7c01_3c00_7e00, 48'h0000_8000_fe00, 48'h7c00_fc00_fe00, 48'h3c00_fd00_fe00},
        '{48'h3c00_0000_7c00, 48'hc000_0000_fc00, 48'h7c00_4000_7c00, 48'hfc00_4000_fc00},
        '{48'h0000_4000_0000, 48'h8000_4000_8000, 48'h4000_7c00_0000, 48'h4000_fc00_8000},
        // Subnormal inputs behave as zero
        '{48'h0001_3c00_0000, 48'h3c00_0200_7c00, 48'h8010_3c00_8000, 48'h0001_0001_7e00},
        // Overflow, subnormal and flushed results
        '{48'h7bff_3800_7c00, 48'hf800_1400_fc00, 48'h0400_4400_0100, 48'h8400_7800_8000},
        '{48'h0400_4200_0155, 48'h8400_4500_80cd, 48'h3c00_7bff_0100, 48'h7bff_7bff_3c00}
    };

    logic     CLK;
    logic     nRST;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    int       checks = 0;
    int       mismatches = 0;
    int       other_errors = 0;
    int       seed = 32'ha2ac;

    vdiv_clk_gen #(
        .PERIOD      (CLK_PERIOD),
        .RESET_CYCLES(8)
    ) clk_gen_i (
        .CLK (CLK),
        .nRST(nRST)
    );

    vdiv_top #(
        .LANES   (LANES),
        .DIV_SIZE(23),
        .DIV_SKIP(11)
    ) vdiv_top_i (
        .CLK    (CLK),
        .nRST   (nRST),
        .apb_req(apb_req),
        .apb_rsp(apb_rsp)
    );

    task automatic check_fp16(input fp16_t got, input fp16_t exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_status(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
            mismatches++;
        end
    endtask

    // Setup and access cycles, then one idle cycle
    // Response sampled in the middle of the access cycle
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic err);
        @(negedge CLK);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(negedge CLK);
        apb_req.penable = 1'b1;
        #(CLK_PERIOD / 4);
        err = apb_rsp.pslverr;
        check_status(apb_rsp.pready, 1'b1, "pready in write access");
        @(negedge CLK);
        apb_req = '0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        @(negedge CLK);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'h0};
        @(negedge CLK);
        apb_req.penable = 1'b1;
        #(CLK_PERIOD / 4);
        data = apb_rsp.prdata;
        err  = apb_rsp.pslverr;
        check_status(apb_rsp.pready, 1'b1, "pready in read access");
        @(negedge CLK);
        apb_req = '0;
    endtask

    // Class 0 NaN, 1 infinity, anything else zero
    function automatic fp16_t make_special(input int cls, input logic [31:0] r);
        case (cls)
            0:       return {r[15], 5'h1f, r[9:0] | 10'h001};
            1:       return {r[15], 5'h1f, 10'h000};
            default: return {r[15], 15'h0000};
        endcase
    endfunction

    function automatic fp16_t expect_special(input int cls_a, input int cls_b,
                                             input logic sign);
        // NaN in, 0/0 and inf/inf give NaN; inf/0 gives inf; 0/inf gives zero
        if (cls_a == 0 || cls_b == 0 || cls_a == cls_b)
            return {sign, FP16_QNAN[14:0]};
        if (cls_a == 1)
            return {sign, 5'h1f, 10'h000};
        return {sign, 15'h0000};
    endfunction

    task automatic run_vector(input int row, input fp16_t [LANES-1:0] a,
                              input fp16_t [LANES-1:0] b, input fp16_t [LANES-1:0] exp_r,
                              input logic probe_busy);
        logic [31:0] rd;
        logic        err;
        int          polls;
        for (int i = 0; i < LANES; i++) begin
            apb_write(REG_A_BASE + 8'(4 * i), {16'h0, a[i]}, err);
            check_status(err, 1'b0, "pslverr on operand A write");
            apb_write(REG_B_BASE + 8'(4 * i), {16'h0, b[i]}, err);
            check_status(err, 1'b0, "pslverr on operand B write");
        end
        apb_write(REG_CTRL, 32'h1, err);
        check_status(err, 1'b0, "pslverr on start");
        apb_read(REG_STATUS, rd, err);
        check_status(rd[0], 1'b1, "STATUS busy after start");
        check_status(rd[1], 1'b0, "STATUS done after start");
        if (probe_busy) begin
            apb_write(REG_CTRL, 32'h1, err);
            check_status(err, 1'b1, "pslverr on start while busy");
            apb_write(REG_A_BASE, 32'h0000_1234, err);
            check_status(err, 1'b1, "pslverr on A write while busy");
            apb_write(REG_B_BASE + 8'h4, 32'h0000_5678, err);
            check_status(err, 1'b1, "pslverr on B write while busy");
        end
        polls = 0;
        rd = 32'h1;
        while (rd[0] && polls < POLL_LIMIT) begin
            apb_read(REG_STATUS, rd, err);
            polls++;
        end
        if (rd[0]) begin
            $display("Row %0d: busy still set after %0d status polls", row, polls);
            other_errors++;
        end
        check_status(rd[1], 1'b1, "STATUS done at end");
        for (int i = 0; i < LANES; i++) begin
            apb_read(REG_R_BASE + 8'(4 * i), rd, err);
            check_fp16(fp16_t'(rd[15:0]), exp_r[i], $sformatf("row %0d lane %0d", row, i));
        end
        if (probe_busy) begin
            apb_read(REG_A_BASE, rd, err);
            check_fp16(fp16_t'(rd[15:0]), a[0], "A lane 0 after blocked write");
            apb_read(REG_B_BASE + 8'h4, rd, err);
            check_fp16(fp16_t'(rd[15:0]), b[1], "B lane 1 after blocked write");
        end
    endtask

    initial begin
        repeat ((NUM_ROWS + NUM_RAND) * ROW_CYCLES + MARGIN_CYCLES) @(posedge CLK);
        $display("Timeout: the tests did not finish in the expected number of cycles");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        fp16_t [LANES-1:0] va;
        fp16_t [LANES-1:0] vb;
        fp16_t [LANES-1:0] vr;
        int                cls_a;
        int                cls_b;
        int                assert_fails;
        logic [31:0]       rd;
        logic              err;
        apb_req = '0;
        wait (nRST === 1'b1);
        for (int row = 0; row < NUM_ROWS; row++) begin
            for (int i = 0; i < LANES; i++) begin
                va[i] = VECS[row][i][47:32];
                vb[i] = VECS[row][i][31:16];
                vr[i] = VECS[row][i][15:0];
            end
            run_vector(row, va, vb, vr, row == 0);
        end
        for (int row = 0; row < NUM_RAND; row++) begin
            for (int i = 0; i < LANES; i++) begin
                cls_a = $unsigned($random(seed)) % 3;
                cls_b = $unsigned($random(seed)) % 3;
                va[i] = make_special(cls_a, $random(seed));
                vb[i] = make_special(cls_b, $random(seed));
                vr[i] = expect_special(cls_a, cls_b, va[i].sign ^ vb[i].sign);
            end
            run_vector(NUM_ROWS + row, va, vb, vr, 1'b0);
        end
        // Unmapped and misaligned addresses
        apb_read(8'h08, rd, err);
        check_status(err, 1'b1, "pslverr on read of 0x08");
        apb_write(8'h40, 32'h1, err);
        check_status(err, 1'b1, "pslverr on write of 0x40");
        apb_read(REG_A_BASE + 8'h2, rd, err);
        check_status(err, 1'b1, "pslverr on misaligned read");
        assert_fails = vdiv_top_i.seq_i.seq_chk_i.fail_count
                     + vdiv_top_i.regs_i.regs_chk_i.fail_count;
        $display("Checks %0d, mismatches %0d, other errors %0d, assertion failures %0d",
                 checks, mismatches, other_errors, assert_fails);
        if (mismatches == 0 && other_errors == 0 && assert_fails == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
hdl/vdiv_pkg.sv
hdl/int_divider.sv
hdl/fp16_div.sv
hdl/vdiv_regs.sv
hdl/vdiv_seq.sv
hdl/vdiv_top.sv
testbench/vdiv_clk_gen.sv
testbench/vdiv_asserts.sv
testbench/vdiv_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the vector FP16 divide testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module vdiv_tb -Mdir obj_dir -o vdiv_sim -f vlog.f

# The log decides the result, so a stopped run still reaches the search
./obj_dir/vdiv_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST PASSED" sim.log; then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation failed, see sim.log"
exit 1
